// File: design/arbiter_config.svh
`ifndef ARBITER_CONFIG_SVH
`define ARBITER_CONFIG_SVH

// Beat widths
`define DATA_WIDTH 32
`define KEEP_WIDTH 4

// Register map
`define REG_ADDR_WIDTH 2
`define REG_MODE 2'd0
`define REG_STATUS 2'd1

`endif

// File: design/arbiter_pkg.sv
`include "arbiter_config.svh"

package arbiter_pkg;

	typedef logic [`DATA_WIDTH-1:0] word_t;
	typedef logic [`KEEP_WIDTH-1:0] keep_t;
	typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;

	// One stream beat, 37 bits
	typedef struct packed {
		word_t data;
		keep_t keep;
		logic last;
	} beat_t;

	// Ownership of the shared port
	typedef enum logic [1:0] {
		own_untrusted = 2'd0,
		own_trusted = 2'd1,
		drain_to_untrusted = 2'd2,
		drain_to_trusted = 2'd3
	} owner_state_t;

endpackage

// File: design/ctrl_regs.sv
`timescale 1ns/1ns
`include "arbiter_config.svh"

module ctrl_regs
(
	input logic clk,
	input logic rst,
	input logic reg_wr,
	input logic reg_rd,
	input arbiter_pkg::reg_addr_t reg_addr,
	input arbiter_pkg::word_t reg_wdata,
	input arbiter_pkg::owner_state_t state,
	output arbiter_pkg::word_t reg_rdata,
	output logic reg_rvalid,
	output logic mode
);

	////////////////////////////////////////
	// Mode register
	////////////////////////////////////////

	// Bit 0 set requests trusted ownership
	always_ff @(posedge clk)
	begin
		if (rst)
			mode <= 1'b0;
		else if (reg_wr && reg_addr == `REG_MODE)
			mode <= reg_wdata[0];
	end

	////////////////////////////////////////
	// Read port
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
			reg_rvalid <= 1'b0;
		else
			reg_rvalid <= reg_rd;
	end

	always_ff @(posedge clk)
	begin
		if (reg_rd)
		begin
			case (reg_addr)
				`REG_MODE: reg_rdata <= arbiter_pkg::word_t'(mode);
				`REG_STATUS: reg_rdata <= arbiter_pkg::word_t'(state);
				default: reg_rdata <= '0;
			endcase
		end
	end

	// One response per request, one cycle later, with known data
	rvalid_follows_read: assert property (
		@(posedge clk) disable iff (rst)
		reg_rvalid |-> $past(reg_rd) && !$isunknown(reg_rdata)
	);

endmodule

// File: design/owner_fsm.sv
`timescale 1ns/1ns

module owner_fsm
(
	input logic clk,
	input logic rst,
	input logic mode,
	input logic tx_fire,
	input logic tx_last,
	input logic rx_fire,
	input logic rx_last,
	output arbiter_pkg::owner_state_t state,
	output logic trusted
);

	logic tx_open;
	logic rx_open;
	logic busy;
	arbiter_pkg::owner_state_t state_next;

	////////////////////////////////////////
	// Open packet tracking
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
			tx_open <= 1'b0;
		else if (tx_fire)
			tx_open <= !tx_last;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			rx_open <= 1'b0;
		else if (rx_fire)
			rx_open <= !rx_last;
	end

	// A handshake in this cycle still counts as traffic
	assign busy = tx_open || rx_open || tx_fire || rx_fire;

	////////////////////////////////////////
	// Ownership FSM
	////////////////////////////////////////

	always_comb
	begin
		state_next = state;
		case (state)
			arbiter_pkg::own_untrusted:
				if (mode)
					state_next = arbiter_pkg::drain_to_trusted;
			arbiter_pkg::own_trusted:
				if (!mode)
					state_next = arbiter_pkg::drain_to_untrusted;
			arbiter_pkg::drain_to_trusted:
				if (!mode)
					state_next = arbiter_pkg::own_untrusted;
				else if (!busy)
					state_next = arbiter_pkg::own_trusted;
			arbiter_pkg::drain_to_untrusted:
				if (mode)
					state_next = arbiter_pkg::own_trusted;
				else if (!busy)
					state_next = arbiter_pkg::own_untrusted;
			default:
				state_next = arbiter_pkg::own_untrusted;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			state <= arbiter_pkg::own_untrusted;
		else
			state <= state_next;
	end

	// Old owner keeps the port while draining
	assign trusted = (state == arbiter_pkg::own_trusted) ||
		(state == arbiter_pkg::drain_to_untrusted);

	// No switch in the middle of a packet
	owner_held_in_packet: assert property (
		@(posedge clk) disable iff (rst)
		(tx_open || rx_open) |=> $stable(trusted)
	);

endmodule

// File: design/stream_switch.sv
`timescale 1ns/1ns

module stream_switch
(
	input logic trusted,
	// Transmit side
	input arbiter_pkg::beat_t t_tx,
	input logic t_tx_valid,
	input arbiter_pkg::beat_t u_tx,
	input logic u_tx_valid,
	input logic o_tx_ready,
	output arbiter_pkg::beat_t o_tx,
	output logic o_tx_valid,
	output logic t_tx_ready,
	output logic u_tx_ready,
	// Receive side
	input arbiter_pkg::beat_t o_rx,
	input logic o_rx_valid,
	input logic t_rx_ready,
	input logic u_rx_ready,
	output arbiter_pkg::beat_t t_rx,
	output logic t_rx_valid,
	output arbiter_pkg::beat_t u_rx,
	output logic u_rx_valid,
	output logic o_rx_ready,
	// Handshakes on the shared port
	output logic tx_fire,
	output logic rx_fire
);

	////////////////////////////////////////
	// Transmit multiplexer
	////////////////////////////////////////

	assign o_tx = trusted ? t_tx : u_tx;
	assign o_tx_valid = trusted ? t_tx_valid : u_tx_valid;
	assign t_tx_ready = trusted && o_tx_ready;
	assign u_tx_ready = !trusted && o_tx_ready;

	////////////////////////////////////////
	// Receive demultiplexer
	////////////////////////////////////////

	// Non-owner sees an idle, zeroed stream
	assign t_rx = trusted ? o_rx : '0;
	assign u_rx = trusted ? '0 : o_rx;
	assign t_rx_valid = trusted && o_rx_valid;
	assign u_rx_valid = !trusted && o_rx_valid;
	assign o_rx_ready = trusted ? t_rx_ready : u_rx_ready;

	assign tx_fire = o_tx_valid && o_tx_ready;
	assign rx_fire = o_rx_valid && o_rx_ready;

endmodule

// File: design/network_arbiter.sv
`timescale 1ns/1ns

module network_arbiter
(
	input logic clk,
	input logic rst,
	// Register port
	input logic reg_wr,
	input logic reg_rd,
	input arbiter_pkg::reg_addr_t reg_addr,
	input arbiter_pkg::word_t reg_wdata,
	output arbiter_pkg::word_t reg_rdata,
	output logic reg_rvalid,
	// Trusted client
	input arbiter_pkg::beat_t t_tx,
	input logic t_tx_valid,
	output logic t_tx_ready,
	output arbiter_pkg::beat_t t_rx,
	output logic t_rx_valid,
	input logic t_rx_ready,
	// Untrusted client
	input arbiter_pkg::beat_t u_tx,
	input logic u_tx_valid,
	output logic u_tx_ready,
	output arbiter_pkg::beat_t u_rx,
	output logic u_rx_valid,
	input logic u_rx_ready,
	// Shared network port
	output arbiter_pkg::beat_t o_tx,
	output logic o_tx_valid,
	input logic o_tx_ready,
	input arbiter_pkg::beat_t o_rx,
	input logic o_rx_valid,
	output logic o_rx_ready,
	output logic trusted
);

	logic mode;
	logic tx_fire;
	logic rx_fire;
	arbiter_pkg::owner_state_t state;

	ctrl_regs ctrl_regs_inst (
		.clk(clk),
		.rst(rst),
		.reg_wr(reg_wr),
		.reg_rd(reg_rd),
		.reg_addr(reg_addr),
		.reg_wdata(reg_wdata),
		.state(state),
		.reg_rdata(reg_rdata),
		.reg_rvalid(reg_rvalid),
		.mode(mode)
	);

	// Packet ends are seen on the shared side
	owner_fsm owner_fsm_inst (
		.clk(clk),
		.rst(rst),
		.mode(mode),
		.tx_fire(tx_fire),
		.tx_last(o_tx.last),
		.rx_fire(rx_fire),
		.rx_last(o_rx.last),
		.state(state),
		.trusted(trusted)
	);

	stream_switch stream_switch_inst (
		.trusted(trusted),
		.t_tx(t_tx),
		.t_tx_valid(t_tx_valid),
		.u_tx(u_tx),
		.u_tx_valid(u_tx_valid),
		.o_tx_ready(o_tx_ready),
		.o_tx(o_tx),
		.o_tx_valid(o_tx_valid),
		.t_tx_ready(t_tx_ready),
		.u_tx_ready(u_tx_ready),
		.o_rx(o_rx),
		.o_rx_valid(o_rx_valid),
		.t_rx_ready(t_rx_ready),
		.u_rx_ready(u_rx_ready),
		.t_rx(t_rx),
		.t_rx_valid(t_rx_valid),
		.u_rx(u_rx),
		.u_rx_valid(u_rx_valid),
		.o_rx_ready(o_rx_ready),
		.tx_fire(tx_fire),
		.rx_fire(rx_fire)
	);

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/1ns

module tb_clock
(
	output logic clk
);

	// 40 ns period
	initial
	begin
		clk = 1'b0;
		forever
			#20 clk = ~clk;
	end

endmodule

// File: tests/network_arbiter_tb.sv
`timescale 1ns/1ns
`include "arbiter_config.svh"

module network_arbiter_tb;

	localparam int TRAFFIC_CYCLES = 200;
	// Reset, both traffic runs and the register steps
	localparam int TEST_CYCLES = 8 + 2 * TRAFFIC_CYCLES + 120;
	localparam int MARGIN_CYCLES = 100;
	localparam int WAIT_LIMIT = 16;

	typedef struct packed {
		arbiter_pkg::beat_t o_tx;
		arbiter_pkg::beat_t t_rx;
		arbiter_pkg::beat_t u_rx;
		logic o_tx_valid;
		logic t_rx_valid;
		logic u_rx_valid;
		logic t_tx_ready;
		logic u_tx_ready;
		logic o_rx_ready;
	} route_t;

	logic clk, rst, trusted;
	logic reg_wr, reg_rd, reg_rvalid;
	arbiter_pkg::reg_addr_t reg_addr;
	arbiter_pkg::word_t reg_wdata, reg_rdata;
	arbiter_pkg::beat_t t_tx, u_tx, o_tx, t_rx, u_rx, o_rx;
	logic t_tx_valid, u_tx_valid, o_tx_valid, t_rx_valid, u_rx_valid, o_rx_valid;
	logic t_tx_ready, u_tx_ready, o_tx_ready, t_rx_ready, u_rx_ready, o_rx_ready;

	logic [31:0] lfsr;
	arbiter_pkg::owner_state_t m_state;
	logic m_mode, m_tx_open, m_rx_open, m_rvalid;
	arbiter_pkg::word_t m_rdata;
	logic t_tx_moved, u_tx_moved, o_rx_moved;

	tb_clock clock_inst (.clk(clk));

	network_arbiter network_arbiter_inst (.*);

	////////////////////////////////////////
	// Random source and reference model
	////////////////////////////////////////

	// Taps 32 22 2 1
	function automatic logic random_bit();
		lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
		return lfsr[0];
	endfunction

	function automatic logic [31:0] take_bits(int n);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++)
			bits = {bits[30:0], random_bit()};
		return bits;
	endfunction

	function automatic arbiter_pkg::beat_t random_beat(logic force_last);
		arbiter_pkg::beat_t b;
		b.data = take_bits(32);
		b.keep = arbiter_pkg::keep_t'(take_bits(4));
		// Roughly one beat in four closes its packet
		b.last = (take_bits(2) == 32'd3) || force_last;
		return b;
	endfunction

	// Owner gets the whole port
	function automatic route_t expected_route(logic own_t,
		arbiter_pkg::beat_t tt, logic tt_valid, arbiter_pkg::beat_t ut, logic ut_valid,
		logic ot_ready, arbiter_pkg::beat_t orx, logic or_valid, logic tr_ready, logic ur_ready);
		route_t r;
		r = '0;
		if (own_t)
		begin
			r.o_tx = tt;
			r.o_tx_valid = tt_valid;
			r.t_tx_ready = ot_ready;
			r.t_rx = orx;
			r.t_rx_valid = or_valid;
			r.o_rx_ready = tr_ready;
		end
		else
		begin
			r.o_tx = ut;
			r.o_tx_valid = ut_valid;
			r.u_tx_ready = ot_ready;
			r.u_rx = orx;
			r.u_rx_valid = or_valid;
			r.o_rx_ready = ur_ready;
		end
		return r;
	endfunction

	function automatic arbiter_pkg::owner_state_t next_state(
		arbiter_pkg::owner_state_t s, logic want_t, logic busy);
		arbiter_pkg::owner_state_t n;
		n = s;
		case (s)
			arbiter_pkg::own_untrusted:
				n = want_t ? arbiter_pkg::drain_to_trusted : s;
			arbiter_pkg::own_trusted:
				n = want_t ? s : arbiter_pkg::drain_to_untrusted;
			arbiter_pkg::drain_to_trusted:
				n = !want_t ? arbiter_pkg::own_untrusted : (busy ? s : arbiter_pkg::own_trusted);
			arbiter_pkg::drain_to_untrusted:
				n = want_t ? arbiter_pkg::own_trusted : (busy ? s : arbiter_pkg::own_untrusted);
		endcase
		return n;
	endfunction

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	task automatic fail_now(string reason);
		$display("%s", reason);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic check_beat(string name, arbiter_pkg::beat_t actual,
		arbiter_pkg::beat_t expected);
		if (actual !== expected)
			fail_now($sformatf("ERROR at %0t ns: %s is %h, expected %h", $time, name,
				actual, expected));
	endtask

	task automatic check_word(string name, arbiter_pkg::word_t actual,
		arbiter_pkg::word_t expected);
		if (actual !== expected)
			fail_now($sformatf("ERROR at %0t ns: %s is %h, expected %h", $time, name,
				actual, expected));
	endtask

	task automatic check_bit(string name, logic actual, logic expected);
		if (actual !== expected)
			fail_now($sformatf("ERROR at %0t ns: %s is %b, expected %b", $time, name,
				actual, expected));
	endtask

	always @(posedge clk)
	begin
		route_t want_r;
		logic own_t;
		logic tx_fire;
		logic rx_fire;
		if (rst)
		begin
			m_state = arbiter_pkg::own_untrusted;
			m_mode = 1'b0;
			m_tx_open = 1'b0;
			m_rx_open = 1'b0;
			m_rvalid = 1'b0;
			t_tx_moved = 1'b0;
			u_tx_moved = 1'b0;
			o_rx_moved = 1'b0;
		end
		else
		begin
			own_t = (m_state == arbiter_pkg::own_trusted) ||
				(m_state == arbiter_pkg::drain_to_untrusted);
			want_r = expected_route(own_t, t_tx, t_tx_valid, u_tx, u_tx_valid, o_tx_ready,
				o_rx, o_rx_valid, t_rx_ready, u_rx_ready);
			check_bit("trusted", trusted, own_t);
			check_beat("o_tx", o_tx, want_r.o_tx);
			check_bit("o_tx_valid", o_tx_valid, want_r.o_tx_valid);
			check_bit("t_tx_ready", t_tx_ready, want_r.t_tx_ready);
			check_bit("u_tx_ready", u_tx_ready, want_r.u_tx_ready);
			check_beat("t_rx", t_rx, want_r.t_rx);
			check_bit("t_rx_valid", t_rx_valid, want_r.t_rx_valid);
			check_beat("u_rx", u_rx, want_r.u_rx);
			check_bit("u_rx_valid", u_rx_valid, want_r.u_rx_valid);
			check_bit("o_rx_ready", o_rx_ready, want_r.o_rx_ready);
			check_bit("reg_rvalid", reg_rvalid, m_rvalid);
			if (m_rvalid)
				check_word("reg_rdata", reg_rdata, m_rdata);

			// Advance the model by one edge
			tx_fire = want_r.o_tx_valid && o_tx_ready;
			rx_fire = o_rx_valid && want_r.o_rx_ready;
			t_tx_moved = t_tx_valid && want_r.t_tx_ready;
			u_tx_moved = u_tx_valid && want_r.u_tx_ready;
			o_rx_moved = rx_fire;
			m_rvalid = reg_rd;
			if (reg_rd)
			begin
				case (reg_addr)
					`REG_MODE: m_rdata = arbiter_pkg::word_t'(m_mode);
					`REG_STATUS: m_rdata = arbiter_pkg::word_t'(m_state);
					default: m_rdata = '0;
				endcase
			end
			m_state = next_state(m_state, m_mode, m_tx_open || m_rx_open || tx_fire || rx_fire);
			if (tx_fire)
				m_tx_open = !want_r.o_tx.last;
			if (rx_fire)
				m_rx_open = !o_rx.last;
			if (reg_wr && reg_addr == `REG_MODE)
				m_mode = reg_wdata[0];
		end
	end

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	task automatic drive_idle();
		t_tx = '0;
		u_tx = '0;
		o_rx = '0;
		t_tx_valid = 1'b0;
		u_tx_valid = 1'b0;
		o_rx_valid = 1'b0;
		o_tx_ready = 1'b0;
		t_rx_ready = 1'b0;
		u_rx_ready = 1'b0;
	endtask

	// Flush forces last beats and full readiness so open packets close
	task automatic drive_traffic(int cycles, logic flush);
		for (int i = 0; i < cycles; i++)
		begin
			@(negedge clk);
			if (!t_tx_valid || t_tx_moved)
			begin
				t_tx = random_beat(flush);
				t_tx_valid = random_bit() || flush;
			end
			if (!u_tx_valid || u_tx_moved)
			begin
				u_tx = random_beat(flush);
				u_tx_valid = random_bit() || flush;
			end
			if (!o_rx_valid || o_rx_moved)
			begin
				o_rx = random_beat(flush);
				o_rx_valid = random_bit() || flush;
			end
			o_tx_ready = random_bit() || flush;
			t_rx_ready = random_bit() || flush;
			u_rx_ready = random_bit() || flush;
		end
	endtask

	task automatic write_reg(arbiter_pkg::reg_addr_t addr, arbiter_pkg::word_t data);
		@(negedge clk);
		reg_wr = 1'b1;
		reg_addr = addr;
		reg_wdata = data;
		@(negedge clk);
		reg_wr = 1'b0;
	endtask

	task automatic read_expect(arbiter_pkg::reg_addr_t addr, arbiter_pkg::word_t expected);
		int waited;
		waited = 0;
		@(negedge clk);
		reg_rd = 1'b1;
		reg_addr = addr;
		@(negedge clk);
		reg_rd = 1'b0;
		while (!reg_rvalid)
		begin
			if (waited == WAIT_LIMIT)
				fail_now("Register read got no response");
			waited++;
			@(negedge clk);
		end
		check_word("reg_rdata", reg_rdata, expected);
		@(negedge clk);
		check_bit("reg_rvalid", reg_rvalid, 1'b0);
	endtask

	task automatic wait_trusted(logic value);
		int waited;
		waited = 0;
		while (trusted !== value)
		begin
			if (waited == WAIT_LIMIT)
				fail_now("Ownership did not switch within the wait limit");
			waited++;
			@(negedge clk);
		end
	endtask

	initial
	begin
		lfsr = 32'ha105_6370;
		rst = 1'b1;
		reg_wr = 1'b0;
		reg_rd = 1'b0;
		reg_addr = '0;
		reg_wdata = '0;
		drive_idle();
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		@(negedge clk);
		check_bit("trusted", trusted, 1'b0);
		check_bit("reg_rvalid", reg_rvalid, 1'b0);
		read_expect(`REG_STATUS, arbiter_pkg::word_t'(arbiter_pkg::own_untrusted));

		// Untrusted owner under random back-pressure
		drive_traffic(TRAFFIC_CYCLES, 1'b0);
		drive_traffic(4, 1'b1);
		@(negedge clk);
		drive_idle();

		write_reg(`REG_MODE, 32'hffff_fffe);
		read_expect(`REG_MODE, 32'h0);
		write_reg(2'd2, 32'hdead_beef);
		read_expect(2'd2, 32'h0);

		// Idle switch to trusted
		write_reg(`REG_MODE, 32'h1);
		wait_trusted(1'b1);
		read_expect(`REG_MODE, 32'h1);
		read_expect(`REG_STATUS, arbiter_pkg::word_t'(arbiter_pkg::own_trusted));
		drive_traffic(TRAFFIC_CYCLES, 1'b0);
		drive_traffic(4, 1'b1);
		@(negedge clk);
		drive_idle();

		// Open packet holds the trusted owner
		@(negedge clk);
		o_tx_ready = 1'b1;
		t_tx = {32'h1234_5678, 4'hf, 1'b0};
		t_tx_valid = 1'b1;
		@(negedge clk);
		t_tx_valid = 1'b0;
		write_reg(`REG_MODE, 32'h0);
		repeat (4) @(negedge clk);
		check_bit("trusted", trusted, 1'b1);
		t_tx = {32'h9abc_def0, 4'h3, 1'b1};
		t_tx_valid = 1'b1;
		@(negedge clk);
		t_tx_valid = 1'b0;
		wait_trusted(1'b0);
		read_expect(`REG_STATUS, arbiter_pkg::word_t'(arbiter_pkg::own_untrusted));

		repeat (2) @(negedge clk);
		$display("Everything OK");
		$finish;
	end

	initial
	begin
		#((TEST_CYCLES + MARGIN_CYCLES) * 40);
		fail_now("Watchdog expired before the test finished");
	end

endmodule

// File: list.f
+incdir+design
design/arbiter_pkg.sv
design/ctrl_regs.sv
design/owner_fsm.sv
design/stream_switch.sv
design/network_arbiter.sv
tests/tb_clock.sv
tests/network_arbiter_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = network_arbiter_tb
FILELIST = list.f
OBJ_DIR = obj_dir

SOURCES = $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS = $(wildcard design/*.svh)
SIM = $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out=$$(./$(SIM)); echo "$$out"; echo "$$out" | grep -q "^Everything OK$$"

clean:
	rm -rf $(OBJ_DIR)
